// File: src/ext_pkg.sv
// ========================================================================
// Shared widths, types and constants for the instruction extract stage.
// Import with a wildcard inside a module body; use scoped names in headers.
// ========================================================================
`default_nettype none

package ext_pkg;

	// ========================================================================
	// Basic widths
	// ========================================================================

	// Byte address PC
	localparam int PC_W = 32;
	// One fixed-width instruction slot
	localparam int INS_W = 48;
	// Alignment unit within the cache line
	localparam int PARCEL_W = 16;
	// PC step from one slot to the next
	localparam int INS_BYTES = 6;
	// Full cache line
	localparam int LINE_W = 512;
	// PC bits 5..1 pick the parcel inside the line
	localparam int LINE_IDX_W = 5;
	// Default slot count for the top level
	localparam int MWIDTH_DEF = 4;

	// ========================================================================
	// Derived constants
	// ========================================================================

	// Opcode field sits in the low bits of a slot
	localparam int OPC_W = 7;
	// Displacement / address field occupies the upper 32 bits
	localparam int DISP_LSB = INS_W - PC_W;
	// Bit shift amount = parcel index times parcel width
	localparam int SHIFT_W = LINE_IDX_W + $clog2(PARCEL_W);

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [INS_W-1:0] ins_t;

	// Default PC on the flow outputs when nothing qualifies
	localparam pc_t RSTPC = 32'hFFFC_0100;

	// Opcodes the extract stage cares about; anything else is plain
	typedef enum logic [OPC_W-1:0] {
		OP_NOP = 7'd0,
		OP_ALU = 7'd1,
		OP_BSR = 7'd2,
		OP_JSR = 7'd3,
		OP_BCC = 7'd4,
		OP_RTD = 7'd5
	} opcode_e;

	// Control-flow class of one slot
	typedef enum logic [1:0] {
		FLOW_NONE   = 2'd0,
		FLOW_CALL   = 2'd1,
		FLOW_BRANCH = 2'd2,
		FLOW_RET    = 2'd3
	} flow_e;

endpackage

`default_nettype wire

// File: src/line_align.sv
// ========================================================================
// Aligns a fetched cache line to the fetch PC and cuts it into slots.
// Also remembers the last group so an exact refetch can be suppressed.
// ========================================================================
`default_nettype none

module line_align #(
	parameter int MWIDTH = ext_pkg::MWIDTH_DEF
) (
	input  logic                           clk,
	input  logic                           rst_i,
	input  logic                           en_i,
	input  logic [ext_pkg::LINE_W-1:0]     line_i,
	input  ext_pkg::pc_t                   pc_i,
	output ext_pkg::ins_t [MWIDTH-1:0]     slot_ins_o,
	output ext_pkg::pc_t  [MWIDTH-1:0]     slot_pc_o,
	output logic                           repeat_o
);
	import ext_pkg::*;

	logic [SHIFT_W-1:0] shamt;
	logic [LINE_W-1:0]  aligned;
	logic [LINE_W-1:0]  prev_aligned;
	pc_t                prev_pc;

	// ========================================================================
	// Parcel alignment
	// ========================================================================

	// Parcel index scaled to a bit count
	assign shamt = SHIFT_W'(pc_i[LINE_IDX_W:1]) * SHIFT_W'(PARCEL_W);

	// Logical shift pulls zero (NOP) parcels in from the top
	assign aligned = line_i >> shamt;

	// Cut into slots, each with its own PC
	for (genvar g = 0; g < MWIDTH; g++) begin : g_slot
		assign slot_ins_o[g] = aligned[g*INS_W +: INS_W];
		assign slot_pc_o[g]  = pc_i + PC_W'(g * INS_BYTES);
	end

	// ========================================================================
	// Repeated group detection
	// ========================================================================

	// History of the last enabled fetch
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc      <= '0;
			prev_aligned <= '0;
		end else if (en_i) begin
			prev_pc      <= pc_i;
			prev_aligned <= aligned;
		end
	end

	// Same PC and same aligned bits means the fetch was replayed
	assign repeat_o = (pc_i == prev_pc) && (aligned == prev_aligned);

endmodule

`default_nettype wire

// File: src/slot_decode.sv
// ========================================================================
// Control-flow decode of one instruction slot. Gives its class and target
// and tells whether a pending branch miss lies beyond it. Combinational.
// ========================================================================
`default_nettype none

module slot_decode (
	input  ext_pkg::ins_t  ins_i,
	input  ext_pkg::pc_t   pc_i,
	input  logic           miss_i,
	input  ext_pkg::pc_t   miss_pc_i,
	output ext_pkg::flow_e flow_o,
	output ext_pkg::pc_t   tgt_o,
	output logic           killed_o
);
	import ext_pkg::*;

	opcode_e opc;
	pc_t     disp;

	// Opcode in the low bits and displacement or address in the top 32
	assign opc  = opcode_e'(ins_i[OPC_W-1:0]);
	assign disp = ins_i[DISP_LSB +: PC_W];

	always_comb begin
		flow_o = FLOW_NONE;
		tgt_o  = RSTPC;
		case (opc)
			// PC relative call
			OP_BSR: begin
				flow_o = FLOW_CALL;
				tgt_o  = pc_i + disp;
			end
			// Absolute call whose field is the address itself
			OP_JSR: begin
				flow_o = FLOW_CALL;
				tgt_o  = disp;
			end
			// Conditional branch relative to the slot PC
			OP_BCC: begin
				flow_o = FLOW_BRANCH;
				tgt_o  = pc_i + disp;
			end
			// Return has no target here
			OP_RTD: begin
				flow_o = FLOW_RET;
			end
			default: begin
				flow_o = FLOW_NONE;
			end
		endcase
	end

	// Slot sits before the miss PC so it is on the wrong path
	assign killed_o = miss_i && (miss_pc_i > pc_i);

endmodule

`default_nettype wire

// File: src/flow_select.sv
// ========================================================================
// Picks the first flow-changing slot of a group and registers the
// branch / call / return outputs. Advances only when en_i is high.
// ========================================================================
`default_nettype none

module flow_select #(
	parameter int MWIDTH = ext_pkg::MWIDTH_DEF
) (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            en_i,
	input  logic                            stomp_i,
	input  ext_pkg::flow_e [MWIDTH-1:0]     flow_i,
	input  ext_pkg::pc_t   [MWIDTH-1:0]     tgt_i,
	input  ext_pkg::pc_t   [MWIDTH-1:0]     slot_pc_i,
	output logic                            do_bsr_o,
	output logic                            do_call_o,
	output logic                            do_ret_o,
	output ext_pkg::pc_t                    tgt_o,
	output ext_pkg::pc_t                    ret_pc_o
);
	import ext_pkg::*;

	logic sel_bsr;
	logic sel_call;
	logic sel_ret;
	pc_t  sel_tgt;
	pc_t  sel_ret_pc;

	// ========================================================================
	// Priority pick, lowest slot index wins
	// ========================================================================

	always_comb begin
		logic found;
		found    = 1'b0;
		sel_bsr  = 1'b0;
		sel_call = 1'b0;
		sel_ret  = 1'b0;
		sel_tgt  = RSTPC;
		for (int i = 0; i < MWIDTH; i++) begin
			if (!found && flow_i[i] != FLOW_NONE) begin
				found = 1'b1;
				case (flow_i[i])
					FLOW_CALL: begin
						sel_bsr  = 1'b1;
						sel_call = 1'b1;
						sel_tgt  = tgt_i[i];
					end
					FLOW_BRANCH: begin
						sel_bsr = 1'b1;
						sel_tgt = tgt_i[i];
					end
					default: sel_ret = 1'b1;
				endcase
			end
		end
		// Stomped group changes no flow
		if (stomp_i) begin
			sel_bsr  = 1'b0;
			sel_call = 1'b0;
			sel_ret  = 1'b0;
			sel_tgt  = RSTPC;
		end
	end

	// Return address of the first call, independent of stomp
	// Walk downward so the lowest index is assigned last
	always_comb begin
		sel_ret_pc = RSTPC;
		for (int i = MWIDTH - 1; i >= 0; i--) begin
			if (flow_i[i] == FLOW_CALL)
				sel_ret_pc = slot_pc_i[i] + PC_W'(INS_BYTES);
		end
	end

	// ========================================================================
	// Output register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			do_bsr_o  <= 1'b0;
			do_call_o <= 1'b0;
			do_ret_o  <= 1'b0;
			tgt_o     <= RSTPC;
			ret_pc_o  <= RSTPC;
		end else if (en_i) begin
			do_bsr_o  <= sel_bsr;
			do_call_o <= sel_call;
			do_ret_o  <= sel_ret;
			tgt_o     <= sel_tgt;
			ret_pc_o  <= sel_ret_pc;
		end
	end

endmodule

`default_nettype wire

// File: src/ext_group_reg.sv
// ========================================================================
// Works out the valid bit of every slot and registers the slot group.
// Handles interrupt, stomp, miss kill, replay and single-step gating.
// ========================================================================
`default_nettype none

module ext_group_reg #(
	parameter int MWIDTH = ext_pkg::MWIDTH_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          en_i,
	input  logic                          irq_i,
	input  logic                          stomp_i,
	input  logic                          ssm_i,
	input  logic                          flush_i,
	input  logic                          repeat_i,
	input  logic [MWIDTH-1:0]             killed_i,
	input  ext_pkg::ins_t [MWIDTH-1:0]    slot_ins_i,
	input  ext_pkg::pc_t  [MWIDTH-1:0]    slot_pc_i,
	output ext_pkg::ins_t [MWIDTH-1:0]    slot_ins_o,
	output ext_pkg::pc_t  [MWIDTH-1:0]    slot_pc_o,
	output logic [MWIDTH-1:0]             slot_v_o,
	output logic                          hwi_o,
	output logic                          flush_o
);

	logic              ssm_prev;
	logic              group_ok;
	logic              step_first;
	logic [MWIDTH-1:0] slot_v;

	// ========================================================================
	// Slot validity
	// ========================================================================

	// Conditions that kill the whole group
	assign group_ok = !irq_i && !stomp_i && !repeat_i;

	// Rising edge of single-step lets one instruction through
	assign step_first = ssm_i && !ssm_prev;

	always_comb begin
		for (int g = 0; g < MWIDTH; g++) begin
			slot_v[g] = group_ok && !killed_i[g];
			// In single-step only slot 0 survives, and only once
			if (ssm_i)
				slot_v[g] = slot_v[g] && (g == 0) && step_first;
		end
	end

	// ========================================================================
	// Registers
	// ========================================================================

	// Single-step history follows enabled cycles only
	always_ff @(posedge clk) begin
		if (rst_i)
			ssm_prev <= 1'b0;
		else if (en_i)
			ssm_prev <= ssm_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			slot_v_o <= '0;
			hwi_o    <= 1'b0;
			flush_o  <= 1'b0;
		end else if (en_i) begin
			slot_v_o <= slot_v;
			hwi_o    <= irq_i;
			flush_o  <= flush_i;
		end
	end

	// Slot payload; dead slots go down the pipe as NOPs
	always_ff @(posedge clk) begin
		if (rst_i) begin
			slot_ins_o <= '0;
			slot_pc_o  <= '0;
		end else if (en_i) begin
			for (int g = 0; g < MWIDTH; g++) begin
				slot_ins_o[g] <= slot_v[g] ? slot_ins_i[g] : '0;
				slot_pc_o[g]  <= slot_pc_i[g];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/pipeline_ext.sv
// ========================================================================
// Extract stage top level. Aligns a fetched line into MWIDTH slots,
// qualifies them and resolves control flow, all behind one en_i register.
// ========================================================================
`default_nettype none

module pipeline_ext #(
	parameter int MWIDTH = ext_pkg::MWIDTH_DEF
) (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          en_i,
	input  logic [ext_pkg::LINE_W-1:0]    line_i,
	input  ext_pkg::pc_t                  pc_i,
	input  logic                          irq_i,
	input  logic                          stomp_i,
	input  logic                          ssm_i,
	input  logic                          flush_i,
	input  logic                          miss_i,
	input  ext_pkg::pc_t                  miss_pc_i,
	output ext_pkg::ins_t [MWIDTH-1:0]    slot_ins_o,
	output ext_pkg::pc_t  [MWIDTH-1:0]    slot_pc_o,
	output logic [MWIDTH-1:0]             slot_v_o,
	output logic                          hwi_o,
	output logic                          flush_o,
	output logic                          do_bsr_o,
	output logic                          do_call_o,
	output logic                          do_ret_o,
	output ext_pkg::pc_t                  tgt_o,
	output ext_pkg::pc_t                  ret_pc_o
);
	import ext_pkg::*;

	// Slots must fit inside one cache line
	if (MWIDTH < 1 || MWIDTH * INS_W > LINE_W) begin : g_bad_mwidth
		$error("MWIDTH slots do not fit in one cache line");
	end

	ins_t  [MWIDTH-1:0] slot_ins;
	pc_t   [MWIDTH-1:0] slot_pc;
	flow_e [MWIDTH-1:0] slot_flow;
	pc_t   [MWIDTH-1:0] slot_tgt;
	logic  [MWIDTH-1:0] slot_killed;
	logic               grp_repeat;

	line_align #(.MWIDTH(MWIDTH)) u_line_align (
		.clk        (clk),
		.rst_i      (rst_i),
		.en_i       (en_i),
		.line_i     (line_i),
		.pc_i       (pc_i),
		.slot_ins_o (slot_ins),
		.slot_pc_o  (slot_pc),
		.repeat_o   (grp_repeat)
	);

	// One decoder per slot
	for (genvar g = 0; g < MWIDTH; g++) begin : g_dec
		slot_decode u_slot_decode (
			.ins_i     (slot_ins[g]),
			.pc_i      (slot_pc[g]),
			.miss_i    (miss_i),
			.miss_pc_i (miss_pc_i),
			.flow_o    (slot_flow[g]),
			.tgt_o     (slot_tgt[g]),
			.killed_o  (slot_killed[g])
		);
	end

	flow_select #(.MWIDTH(MWIDTH)) u_flow_select (
		.clk       (clk),
		.rst_i     (rst_i),
		.en_i      (en_i),
		.stomp_i   (stomp_i),
		.flow_i    (slot_flow),
		.tgt_i     (slot_tgt),
		.slot_pc_i (slot_pc),
		.do_bsr_o  (do_bsr_o),
		.do_call_o (do_call_o),
		.do_ret_o  (do_ret_o),
		.tgt_o     (tgt_o),
		.ret_pc_o  (ret_pc_o)
	);

	ext_group_reg #(.MWIDTH(MWIDTH)) u_ext_group_reg (
		.clk        (clk),
		.rst_i      (rst_i),
		.en_i       (en_i),
		.irq_i      (irq_i),
		.stomp_i    (stomp_i),
		.ssm_i      (ssm_i),
		.flush_i    (flush_i),
		.repeat_i   (grp_repeat),
		.killed_i   (slot_killed),
		.slot_ins_i (slot_ins),
		.slot_pc_i  (slot_pc),
		.slot_ins_o (slot_ins_o),
		.slot_pc_o  (slot_pc_o),
		.slot_v_o   (slot_v_o),
		.hwi_o      (hwi_o),
		.flush_o    (flush_o)
	);

endmodule

`default_nettype wire

// File: test/pipeline_ext_properties.sv
// ========================================================================
// Concurrent assertions on the extract stage outputs, bound to the top.
// ========================================================================
`default_nettype none

module pipeline_ext_properties #(
	parameter int MWIDTH = ext_pkg::MWIDTH_DEF
) (
	input logic                       clk,
	input logic                       rst_i,
	input logic                       en_i,
	input ext_pkg::ins_t [MWIDTH-1:0] slot_ins_o,
	input ext_pkg::pc_t  [MWIDTH-1:0] slot_pc_o,
	input logic [MWIDTH-1:0]          slot_v_o,
	input logic                       hwi_o,
	input logic                       flush_o,
	input logic                       do_bsr_o,
	input logic                       do_call_o,
	input logic                       do_ret_o,
	input ext_pkg::pc_t               tgt_o,
	input ext_pkg::pc_t               ret_pc_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// A call is always a taken branch too
	a_call_is_bsr: assert property (@(posedge clk) disable iff (rst_i) do_call_o |-> do_bsr_o)
		else $error("do_call_o high without do_bsr_o");

	a_bsr_ret_excl: assert property (@(posedge clk) disable iff (rst_i) !(do_bsr_o && do_ret_o))
		else $error("do_bsr_o and do_ret_o high together");

	// Stage register frozen while en_i is low
	a_hold: assert property (@(posedge clk) disable iff (rst_i)
		(!en_i && !rst_i) |=> $stable(slot_ins_o) && $stable(slot_pc_o) && $stable(slot_v_o)
			&& $stable(hwi_o) && $stable(flush_o) && $stable(do_bsr_o) && $stable(do_call_o)
			&& $stable(do_ret_o) && $stable(tgt_o) && $stable(ret_pc_o))
		else $error("outputs changed after a cycle with en_i low");

	a_reset_low: assert property (@(posedge clk) rst_i |=> (slot_v_o == '0) && !hwi_o
		&& !flush_o && !do_bsr_o && !do_call_o && !do_ret_o)
		else $error("control outputs not low after a reset edge");

endmodule

bind pipeline_ext pipeline_ext_properties #(.MWIDTH(MWIDTH)) u_pipeline_ext_properties (
	.clk(clk), .rst_i(rst_i), .en_i(en_i), .slot_ins_o(slot_ins_o), .slot_pc_o(slot_pc_o),
	.slot_v_o(slot_v_o), .hwi_o(hwi_o), .flush_o(flush_o), .do_bsr_o(do_bsr_o),
	.do_call_o(do_call_o), .do_ret_o(do_ret_o), .tgt_o(tgt_o), .ret_pc_o(ret_pc_o)
);

`default_nettype wire

// File: test/ext_model.svh
// ========================================================================
// Reference model of the extract stage, included into the testbench body.
// Call step_model on every enabled edge and reset_model on reset edges.
// ========================================================================
`ifndef EXT_MODEL_SVH
`define EXT_MODEL_SVH
`default_nettype none

	// Model history, what the stage has to remember between groups
	pc_t               hist_pc;
	logic [LINE_W-1:0] hist_aligned;
	logic              hist_ssm;

	// Expected outputs after the latest edge
	ins_t [NSLOT-1:0]  exp_ins;
	pc_t  [NSLOT-1:0]  exp_pc;
	logic [NSLOT-1:0]  exp_v;
	logic              exp_hwi;
	logic              exp_flush;
	logic              exp_bsr;
	logic              exp_call;
	logic              exp_ret;
	pc_t               exp_tgt;
	pc_t               exp_ret_pc;

	// Parcel index is PC bits 5..1, one parcel is 16 bits
	function automatic logic [LINE_W-1:0] shift_line(input logic [LINE_W-1:0] line,
			input pc_t pc);
		int parcel;
		parcel = int'(pc[5:1]);
		return line >> (parcel * PARCEL_W);
	endfunction

	// Class of a slot from its opcode bits 6..0
	function automatic flow_e flow_class(input ins_t ins);
		case (ins[6:0])
			OP_BSR, OP_JSR: return FLOW_CALL;
			OP_BCC: return FLOW_BRANCH;
			OP_RTD: return FLOW_RET;
			default: return FLOW_NONE;
		endcase
	endfunction

	// Relative for BSR and BCC, absolute field for JSR
	function automatic pc_t branch_target(input ins_t ins, input pc_t pc);
		case (ins[6:0])
			OP_BSR, OP_BCC: return pc + ins[47:16];
			OP_JSR: return ins[47:16];
			default: return RSTPC;
		endcase
	endfunction

	task automatic reset_model();
		hist_pc = '0;
		hist_aligned = '0;
		hist_ssm = 1'b0;
		exp_ins = '0;
		exp_pc = '0;
		exp_v = '0;
		exp_hwi = 1'b0;
		exp_flush = 1'b0;
		exp_bsr = 1'b0;
		exp_call = 1'b0;
		exp_ret = 1'b0;
		exp_tgt = RSTPC;
		exp_ret_pc = RSTPC;
	endtask

	// One enabled edge with the inputs the DUT sampled there
	task automatic step_model(input logic [LINE_W-1:0] line, input pc_t pc, input logic irq,
			input logic stomp, input logic ssm, input logic flush, input logic miss,
			input pc_t miss_pc);
		logic [LINE_W-1:0] al;
		pc_t               spc;
		ins_t              sins;
		flow_e             cls;
		logic              rep;
		logic              kill;
		logic              first_hit;
		logic              call_seen;
		al = shift_line(line, pc);
		rep = (pc == hist_pc) && (al == hist_aligned);
		first_hit = 1'b0;
		call_seen = 1'b0;
		exp_bsr = 1'b0;
		exp_call = 1'b0;
		exp_ret = 1'b0;
		exp_tgt = RSTPC;
		exp_ret_pc = RSTPC;
		for (int g = 0; g < NSLOT; g++) begin
			spc = pc + 32'(g * INS_BYTES);
			sins = al[g*INS_W +: INS_W];
			cls = flow_class(sins);
			// Miss beyond this slot puts it on the wrong path
			kill = miss && (miss_pc > spc);
			exp_v[g] = !irq && !stomp && !rep && !kill && (!ssm || (g == 0 && !hist_ssm));
			exp_ins[g] = exp_v[g] ? sins : '0;
			exp_pc[g] = spc;
			// First flow slot decides, stomp cancels it
			if (cls != FLOW_NONE && !first_hit) begin
				first_hit = 1'b1;
				if (!stomp) begin
					exp_bsr = (cls == FLOW_CALL) || (cls == FLOW_BRANCH);
					exp_call = (cls == FLOW_CALL);
					exp_ret = (cls == FLOW_RET);
					if (exp_bsr)
						exp_tgt = branch_target(sins, spc);
				end
			end
			if (cls == FLOW_CALL && !call_seen) begin
				call_seen = 1'b1;
				exp_ret_pc = spc + 32'(INS_BYTES);
			end
		end
		exp_hwi = irq;
		exp_flush = flush;
		hist_pc = pc;
		hist_aligned = al;
		hist_ssm = ssm;
	endtask

`default_nettype wire
`endif

// File: test/tb_pipeline_ext.sv
// ========================================================================
// Random testbench for the extract stage, checked each cycle against the
// included reference model. Runs a fixed seed for a fixed number of cycles.
// ========================================================================
`default_nettype none

module tb_pipeline_ext;
	timeunit 1ns;
	timeprecision 1ps;
	import ext_pkg::*;

	localparam int NSLOT = 4;
	localparam int N_CYCLES = 3000;
	localparam int RST_CYCLES = 16;
	localparam int CLK_PERIOD = 20;
	localparam int WORDS_PER_LINE = (LINE_W + INS_W - 1) / INS_W;
	localparam int WATCHDOG_NS = (N_CYCLES + RST_CYCLES + 100) * CLK_PERIOD;

	logic              clk;
	logic              rst_i;
	logic              en_i;
	logic [LINE_W-1:0] line_i;
	pc_t               pc_i;
	logic              irq_i;
	logic              stomp_i;
	logic              ssm_i;
	logic              flush_i;
	logic              miss_i;
	pc_t               miss_pc_i;
	ins_t [NSLOT-1:0]  slot_ins_o;
	pc_t  [NSLOT-1:0]  slot_pc_o;
	logic [NSLOT-1:0]  slot_v_o;
	logic              hwi_o;
	logic              flush_o;
	logic              do_bsr_o;
	logic              do_call_o;
	logic              do_ret_o;
	pc_t               tgt_o;
	pc_t               ret_pc_o;

	int                seed;
	int                errors;
	int                cycles_checked;
	int                ssm_left;
	logic [LINE_W-1:0] next_line;
	pc_t               next_pc;

	`include "ext_model.svh"

	pipeline_ext #(.MWIDTH(NSLOT)) u_pipeline_ext (
		.clk(clk), .rst_i(rst_i), .en_i(en_i), .line_i(line_i), .pc_i(pc_i),
		.irq_i(irq_i), .stomp_i(stomp_i), .ssm_i(ssm_i), .flush_i(flush_i),
		.miss_i(miss_i), .miss_pc_i(miss_pc_i), .slot_ins_o(slot_ins_o),
		.slot_pc_o(slot_pc_o), .slot_v_o(slot_v_o), .hwi_o(hwi_o), .flush_o(flush_o),
		.do_bsr_o(do_bsr_o), .do_call_o(do_call_o), .do_ret_o(do_ret_o),
		.tgt_o(tgt_o), .ret_pc_o(ret_pc_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ========================================================================
	// Stimulus
	// ========================================================================

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		r = r & 32'h7fff_ffff;
		return r % n;
	endfunction

	// Random 48-bit word, opcode mostly a known one
	function automatic ins_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		int          pick;
		ins_t        w;
		hi = $random(seed);
		lo = $random(seed);
		w = {hi[15:0], lo};
		pick = rand_below(8);
		if (pick < 6)
			w[6:0] = 7'(pick);
		return w;
	endfunction

	task automatic build_line(output logic [LINE_W-1:0] line);
		logic [WORDS_PER_LINE*INS_W-1:0] wide;
		for (int w = 0; w < WORDS_PER_LINE; w++)
			wide[w*INS_W +: INS_W] = rand_word();
		line = wide[LINE_W-1:0];
	endtask

	task automatic drive_next();
		logic [31:0] r;
		int          off;
		// About one fetch in eight replays the previous line and PC
		if (rand_below(8) != 0) begin
			build_line(next_line);
			r = $random(seed);
			next_pc = {r[31:1], 1'b0};
		end
		line_i <= next_line;
		pc_i <= next_pc;
		en_i <= (rand_below(5) != 0);
		// Short single-step bursts with at least one gap cycle
		if (ssm_left > 0)
			ssm_left--;
		else if (rand_below(24) == 0)
			ssm_left = 2 + rand_below(5);
		ssm_i <= (ssm_left > 0);
		irq_i <= (rand_below(16) == 0);
		stomp_i <= (rand_below(16) == 0);
		flush_i <= (rand_below(10) == 0);
		miss_i <= (rand_below(6) == 0);
		// Miss PC a little below up to past the end of the group
		off = rand_below(40) - 8;
		miss_pc_i <= next_pc + 32'(off);
	endtask

	// ========================================================================
	// Checking
	// ========================================================================

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		errors++;
		$display("[FAIL] %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
	endtask

	task automatic check_outputs();
		cycles_checked++;
		for (int g = 0; g < NSLOT; g++) begin
			if (slot_ins_o[g] !== exp_ins[g])
				report_mismatch($sformatf("alignment slot%0d word", g), 64'(exp_ins[g]),
					64'(slot_ins_o[g]));
			if (exp_v[g] && slot_pc_o[g] !== exp_pc[g])
				report_mismatch($sformatf("alignment slot%0d pc", g), 64'(exp_pc[g]),
					64'(slot_pc_o[g]));
		end
		if (slot_v_o !== exp_v)
			report_mismatch("validity slot_v", 64'(exp_v), 64'(slot_v_o));
		if (do_bsr_o !== exp_bsr)
			report_mismatch("flow do_bsr", 64'(exp_bsr), 64'(do_bsr_o));
		if (do_call_o !== exp_call)
			report_mismatch("flow do_call", 64'(exp_call), 64'(do_call_o));
		if (do_ret_o !== exp_ret)
			report_mismatch("flow do_ret", 64'(exp_ret), 64'(do_ret_o));
		if (tgt_o !== exp_tgt)
			report_mismatch("flow target", 64'(exp_tgt), 64'(tgt_o));
		if (ret_pc_o !== exp_ret_pc)
			report_mismatch("return pc", 64'(exp_ret_pc), 64'(ret_pc_o));
		if (hwi_o !== exp_hwi)
			report_mismatch("hwi latency", 64'(exp_hwi), 64'(hwi_o));
		if (flush_o !== exp_flush)
			report_mismatch("flush latency", 64'(exp_flush), 64'(flush_o));
	endtask

	// ========================================================================
	// Main sequence and watchdog
	// ========================================================================

	initial begin
		seed = 32'h2c5d8b84;
		errors = 0;
		cycles_checked = 0;
		ssm_left = 0;
		next_line = '0;
		next_pc = '0;
		rst_i <= 1'b1;
		en_i <= 1'b0;
		line_i <= '0;
		pc_i <= '0;
		irq_i <= 1'b0;
		stomp_i <= 1'b0;
		ssm_i <= 1'b0;
		flush_i <= 1'b0;
		miss_i <= 1'b0;
		miss_pc_i <= '0;
		reset_model();
		for (int c = 0; c < RST_CYCLES + N_CYCLES; c++) begin
			@(posedge clk);
			// Inputs here still hold what the DUT samples on this edge
			if (rst_i)
				reset_model();
			else if (en_i)
				step_model(line_i, pc_i, irq_i, stomp_i, ssm_i, flush_i, miss_i, miss_pc_i);
			if (c == RST_CYCLES - 1)
				rst_i <= 1'b0;
			if (c >= RST_CYCLES - 1)
				drive_next();
			@(negedge clk);
			check_outputs();
		end
		$display("Checked %0d cycles, %0d mismatches", cycles_checked, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the run did not finish in the expected time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+test
src/ext_pkg.sv
src/line_align.sv
src/slot_decode.sv
src/flow_select.sv
src/ext_group_reg.sv
src/pipeline_ext.sv
test/pipeline_ext_properties.sv
test/tb_pipeline_ext.sv

// File: Makefile
# Verilator simulation of the extract stage testbench
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_pipeline_ext
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

# Build, run, and succeed only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
